// File: build.f
hw/csi2_pkg.sv
hw/crc_calc.sv
hw/csi2_pkt_tracker.sv
hw/csi2_crc_calc.sv
hw/csi2_stat_counters.sv
hw/csi2_rx_check.sv
verif/csi2_rx_check_asserts.sv
verif/tb_csi2_rx_check.sv

// File: hw/crc_calc.sv
`timescale 1ns/1ps
`default_nettype none

module crc_calc #(
  parameter int unsigned          CRC_SIZE   = 16,
  parameter int unsigned          DATA_WIDTH = 32,
  parameter logic [CRC_SIZE-1:0]  POLY       = 16'h1021,
  parameter logic [CRC_SIZE-1:0]  INIT       = 16'hffff,
  parameter bit                   REF_IN     = 1'b1,
  parameter bit                   REF_OUT    = 1'b1,
  parameter logic [CRC_SIZE-1:0]  XOR_OUT    = 16'h0000
) (
  input  logic                  clk_i,
  input  logic                  srst_i,
  input  logic                  soft_reset_i,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [CRC_SIZE-1:0]   crc_o
);

  logic [CRC_SIZE-1:0] crc_q;
  logic [CRC_SIZE-1:0] crc_next;
  logic [CRC_SIZE-1:0] crc_refl;

  // with REF_IN the word is taken from bit 0 up, i.e. byte 0 first and each byte lsb first
  always_comb
    begin : fold_word
      logic d;
      logic fb;
      crc_next = crc_q;
      for( int i = 0; i < DATA_WIDTH; i++ )
        begin
          d        = REF_IN ? data_i[i] : data_i[DATA_WIDTH-1-i];
          fb       = crc_next[CRC_SIZE-1] ^ d;
          crc_next = { crc_next[CRC_SIZE-2:0], 1'b0 };
          if( fb )
            crc_next = crc_next ^ POLY;
        end
    end

  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      crc_q <= INIT;
    else
      if( soft_reset_i )
        crc_q <= INIT;   // restart wins over a data word in the same cycle
      else
        if( valid_i )
          crc_q <= crc_next;

  always_comb
    begin
      for( int i = 0; i < CRC_SIZE; i++ )
        crc_refl[i] = crc_q[CRC_SIZE-1-i];
    end

  assign crc_o = ( REF_OUT ? crc_refl : crc_q ) ^ XOR_OUT;

endmodule

`default_nettype wire

// File: hw/csi2_crc_calc.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_crc_calc (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  csi2_pkg::csi2_beat_t    payload_i,
  output csi2_pkg::csi2_crc_res_t crc_res_o
);

  import csi2_pkg::*;

  logic [15:0] main_crc;
  logic [31:0] payload_data;
  logic [15:0] tail_crc;
  logic        eop;
  logic        eop_d1;
  logic        full_d1;
  logic        tail_pass_d1;
  logic        crc_good;

  // reflected CSI-2 update, lsb of the word first
  function automatic logic [15:0] crc_fold(
    input logic [15:0] crc,
    input logic [31:0] data,
    input int unsigned nbits
  );
    logic [15:0] c;
    logic        fb;
    c = crc;
    for( int i = 0; i < 32; i++ )
      if( i < nbits )
        begin
          fb = c[0] ^ data[i];
          c  = c >> 1;
          for( int j = 0; j < 16; j++ )
            if( fb && CSI2_CRC_POLY[j] )
              c[15-j] = ~c[15-j];
        end
    return c;
  endfunction

  assign payload_data = payload_i.data.payload;
  assign eop          = payload_i.valid && payload_i.last;

  crc_calc #(
    .CRC_SIZE     ( 16              ),
    .DATA_WIDTH   ( 32              ),
    .POLY         ( CSI2_CRC_POLY   ),
    .INIT         ( CSI2_CRC_INIT   ),
    .REF_IN       ( 1'b1            ),
    .REF_OUT      ( 1'b1            ),
    .XOR_OUT      ( 16'h0000        )
  ) main_calc (
    .clk_i        ( clk_i           ),
    .srst_i       ( srst_i          ),
    .soft_reset_i ( eop_d1          ),
    .valid_i      ( payload_i.valid ),
    .data_i       ( payload_data    ),
    .crc_o        ( main_crc        )
  );

  // partial last beat is folded here from the crc before that beat
  always_comb
    begin
      case( payload_i.strb )
        4'b0001:
          tail_crc = crc_fold( main_crc, payload_data, 8 );
        4'b0011:
          tail_crc = crc_fold( main_crc, payload_data, 16 );
        4'b0111:
          tail_crc = crc_fold( main_crc, payload_data, 24 );
        default:
          tail_crc = '1;   // full beats are checked on the engine, odd strobes fail
      endcase
    end

  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      begin
        eop_d1       <= 1'b0;
        full_d1      <= 1'b0;
        tail_pass_d1 <= 1'b0;
      end
    else
      begin
        eop_d1       <= eop;
        full_d1      <= eop && ( payload_i.strb == 4'b1111 );
        tail_pass_d1 <= eop && ( tail_crc == '0 );
      end

  // after a full last beat the engine already holds the residue over the whole payload
  always_comb
    begin
      crc_good         = full_d1 ? ( main_crc == '0 ) : tail_pass_d1;
      crc_res_o.passed = eop_d1 && crc_good;
      crc_res_o.failed = eop_d1 && !crc_good;
    end

endmodule

`default_nettype wire

// File: hw/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

  localparam logic [15:0] CSI2_CRC_POLY    = 16'h1021;
  localparam logic [15:0] CSI2_CRC_INIT    = 16'hffff;
  localparam logic [7:0]  CSI2_LONG_ID_MIN = 8'h0f;   // ids above this carry a payload
  localparam int unsigned CSI2_CNT_WIDTH   = 16;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_count;
    logic [7:0]  data_id;
  } csi2_hdr_t;

  // the same stream word is either a header or four payload bytes
  typedef union packed {
    csi2_hdr_t       hdr;
    logic [3:0][7:0] payload;
  } csi2_word_u;

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [3:0] strb;
    csi2_word_u data;
  } csi2_beat_t;

  typedef struct packed {
    logic short_pkt;
    logic long_pkt;
    logic len_err;
  } csi2_pkt_evt_t;

  typedef struct packed {
    logic passed;
    logic failed;
  } csi2_crc_res_t;

  typedef struct packed {
    logic [CSI2_CNT_WIDTH-1:0] short_cnt;
    logic [CSI2_CNT_WIDTH-1:0] long_cnt;
    logic [CSI2_CNT_WIDTH-1:0] crc_err_cnt;
    logic [CSI2_CNT_WIDTH-1:0] len_err_cnt;
  } csi2_stats_t;

endpackage

`default_nettype wire

// File: hw/csi2_pkt_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_pkt_tracker (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  csi2_pkg::csi2_beat_t    pkt_i,
  output csi2_pkg::csi2_beat_t    payload_o,
  output csi2_pkg::csi2_pkt_evt_t pkt_evt_o
);

  import csi2_pkg::*;

  csi2_hdr_t   hdr;
  logic        in_payload;
  logic        hdr_beat;
  logic        pl_beat;
  logic        pl_last;
  logic        long_hdr;
  logic [15:0] word_cnt;
  logic [16:0] byte_cnt;
  logic [16:0] byte_total;
  logic [2:0]  beat_bytes;

  assign hdr        = pkt_i.data.hdr;
  assign hdr_beat   = pkt_i.valid && !in_payload;   // first valid beat outside a payload
  assign pl_beat    = pkt_i.valid && in_payload;
  assign pl_last    = pl_beat && pkt_i.last;
  assign long_hdr   = hdr.data_id > CSI2_LONG_ID_MIN;
  assign beat_bytes = 3'( $countones( pkt_i.strb ) );
  assign byte_total = byte_cnt + 17'( beat_bytes );

  always_comb
    begin
      payload_o       = pkt_i;
      payload_o.valid = pl_beat;   // header beats never reach the CRC block
    end

  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      in_payload <= 1'b0;
    else
      if( hdr_beat && long_hdr && !pkt_i.last )
        in_payload <= 1'b1;
      else
        if( pl_last )
          in_payload <= 1'b0;

  always_ff @( posedge clk_i )
    if( hdr_beat && long_hdr )
      word_cnt <= hdr.word_count;

  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      byte_cnt <= '0;
    else
      if( hdr_beat )
        byte_cnt <= '0;
      else
        if( pl_beat )
          byte_cnt <= byte_total;

  // payload carries word count data bytes plus the two CRC bytes
  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      pkt_evt_o <= '0;
    else
      begin
        pkt_evt_o.short_pkt <= hdr_beat && !long_hdr;
        pkt_evt_o.long_pkt  <= pl_last;
        pkt_evt_o.len_err   <= pl_last && ( byte_total != ( { 1'b0, word_cnt } + 17'd2 ) );
      end

endmodule

`default_nettype wire

// File: hw/csi2_rx_check.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_rx_check #(
  parameter int unsigned CNT_WIDTH = csi2_pkg::CSI2_CNT_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  csi2_pkg::csi2_beat_t    pkt_i,
  output csi2_pkg::csi2_crc_res_t crc_res_o,
  output csi2_pkg::csi2_pkt_evt_t pkt_evt_o,
  output csi2_pkg::csi2_stats_t   stats_o
);

  import csi2_pkg::*;

  csi2_beat_t payload;   // input beats with valid kept only inside a payload

  csi2_pkt_tracker pkt_tracker (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .pkt_i     ( pkt_i     ),
    .payload_o ( payload   ),
    .pkt_evt_o ( pkt_evt_o )
  );

  csi2_crc_calc crc_check (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .payload_i ( payload   ),
    .crc_res_o ( crc_res_o )
  );

  csi2_stat_counters #(
    .CNT_WIDTH ( CNT_WIDTH )
  ) stat_counters (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .pkt_evt_i ( pkt_evt_o ),
    .crc_res_i ( crc_res_o ),
    .stats_o   ( stats_o   )
  );

endmodule

`default_nettype wire

// File: hw/csi2_stat_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_stat_counters #(
  parameter int unsigned CNT_WIDTH = csi2_pkg::CSI2_CNT_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  csi2_pkg::csi2_pkt_evt_t pkt_evt_i,
  input  csi2_pkg::csi2_crc_res_t crc_res_i,
  output csi2_pkg::csi2_stats_t   stats_o
);

  import csi2_pkg::*;

  logic [CNT_WIDTH-1:0] short_cnt;
  logic [CNT_WIDTH-1:0] long_cnt;
  logic [CNT_WIDTH-1:0] crc_err_cnt;
  logic [CNT_WIDTH-1:0] len_err_cnt;

  function automatic logic [CNT_WIDTH-1:0] sat_inc( input logic [CNT_WIDTH-1:0] cnt );
    return ( &cnt ) ? cnt : cnt + 1'b1;   // hold at all ones
  endfunction

  always_ff @( posedge clk_i, posedge srst_i )
    if( srst_i )
      begin
        short_cnt   <= '0;
        long_cnt    <= '0;
        crc_err_cnt <= '0;
        len_err_cnt <= '0;
      end
    else
      begin
        if( pkt_evt_i.short_pkt )
          short_cnt <= sat_inc( short_cnt );
        if( pkt_evt_i.long_pkt )
          long_cnt <= sat_inc( long_cnt );
        if( crc_res_i.failed )
          crc_err_cnt <= sat_inc( crc_err_cnt );
        if( pkt_evt_i.len_err )
          len_err_cnt <= sat_inc( len_err_cnt );
      end

  assign stats_o.short_cnt   = CSI2_CNT_WIDTH'( short_cnt );
  assign stats_o.long_cnt    = CSI2_CNT_WIDTH'( long_cnt );
  assign stats_o.crc_err_cnt = CSI2_CNT_WIDTH'( crc_err_cnt );
  assign stats_o.len_err_cnt = CSI2_CNT_WIDTH'( len_err_cnt );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run from the project root and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f build.f \
       --top-module tb_csi2_rx_check \
  && ./obj_dir/Vtb_csi2_rx_check +verilator+error+limit+100 \
       | tee /dev/stderr | grep -q "Simulation completed successfully" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// File: verif/csi2_rx_check_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_rx_check_asserts (
  input logic                    clk_i,
  input logic                    srst_i,
  input csi2_pkg::csi2_beat_t    payload_i,
  input csi2_pkg::csi2_crc_res_t crc_res_i
);

  int   fail_cnt = 0;
  logic crc_any;

  assign crc_any = crc_res_i.passed || crc_res_i.failed;

  pass_fail_exclusive : assert property ( @( posedge clk_i ) disable iff ( srst_i )
    !( crc_res_i.passed && crc_res_i.failed ) )
    else
      begin
        $error( "crc passed and failed are high together" );
        fail_cnt = fail_cnt + 1;
      end

  // a result belongs to the payload beat that ended the packet one cycle earlier
  result_after_last : assert property ( @( posedge clk_i ) disable iff ( srst_i )
    crc_any |-> $past( payload_i.valid && payload_i.last ) )
    else
      begin
        $error( "crc result without a preceding last payload beat" );
        fail_cnt = fail_cnt + 1;
      end

endmodule

`default_nettype wire

// File: verif/csi2_testdata.txt
# B valid last strb data: one stream beat in hex, data is {byte3,byte2,byte1,byte0}
# E name passed failed long short len_err: pulses expected after the packet above
# S short long crc_err len_err: final counter values in decimal
B 1 0 f 00000a2b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 1 f 006f9139
E full_crc_ok 1 0 1 0 0
B 1 1 f 00000100
E short_fs 0 0 0 1 0
B 1 0 f 00000b2b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 0 f 006f9139
B 1 1 1 00000000
E tail1_crc_ok 1 0 1 0 0
B 1 0 f 00000b2b
B 1 0 f 34333230
B 1 0 f 38373635
B 1 0 f 006f9139
B 1 1 1 00000000
E tail1_crc_bad 0 1 1 0 0
B 1 0 f 00000c2b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 0 f 006f9139
B 1 1 3 00000000
E tail2_crc_ok 1 0 1 0 0
B 1 0 f 00000c2b
B 1 0 f 34333231
B 1 0 f 38373625
B 1 0 f 006f9139
B 1 1 3 00000000
E tail2_crc_bad 0 1 1 0 0
B 1 0 f 0000092b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 1 7 006f9139
E tail3_crc_ok 1 0 1 0 0
B 1 0 f 0000092b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 1 7 006f9138
E tail3_crc_bad 0 1 1 0 0
B 1 0 f 00000a2b
B 1 0 f 34333231
B 1 0 f 38373635
B 1 1 7 006f9139
E len_err 1 0 1 0 1
B 1 0 f 0000002b
B 1 1 3 0000ffff
E empty_payload 1 0 1 0 0
B 1 1 f 00000101
E short_fe 0 0 0 1 0
S 2 9 3 1

// File: verif/tb_csi2_rx_check.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csi2_rx_check;

  import csi2_pkg::*;

  typedef logic [8*24-1:0] name_t;

  logic          clk_i = 1'b0;
  logic          srst_i;
  csi2_beat_t    pkt_i;
  csi2_crc_res_t crc_res_o;
  csi2_pkt_evt_t pkt_evt_o;
  csi2_stats_t   stats_o;

  csi2_beat_t    beats_q[$];
  int            pkt_end_q[$];   // one past the last beat of each packet
  int            gap_q[$];
  name_t         name_q[$];
  csi2_crc_res_t crc_exp_q[$];
  csi2_pkt_evt_t evt_exp_q[$];
  int            due_q[$];       // cycle in which a pending packet reports
  int            due_pkt_q[$];
  csi2_stats_t   stats_exp = '1;
  bit            stats_seen = 1'b0;
  int            cyc = 0;
  int            watchdog_cycles = 0;
  bit            checking = 1'b0;
  int            crc_errs = 0;
  int            evt_errs = 0;
  int            stats_errs = 0;
  int            other_errs = 0;

  csi2_rx_check #(
    .CNT_WIDTH ( CSI2_CNT_WIDTH )
  ) csi2_rx_check_i (
    .clk_i     ( clk_i          ),
    .srst_i    ( srst_i         ),
    .pkt_i     ( pkt_i          ),
    .crc_res_o ( crc_res_o      ),
    .pkt_evt_o ( pkt_evt_o      ),
    .stats_o   ( stats_o        )
  );

  bind csi2_rx_check csi2_rx_check_asserts rx_asserts (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .payload_i ( payload   ),
    .crc_res_i ( crc_res_o )
  );

  always #5 clk_i = ~clk_i;

  always @( posedge clk_i )
    cyc <= cyc + 1;

  function automatic logic [31:0] lcg_next( input logic [31:0] state );
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_testdata();
    int            fd;
    int            n;
    string         line;
    logic [31:0]   v, l, s, d;
    int            e_pass, e_fail, e_long, e_short, e_len;
    name_t         name;
    csi2_beat_t    beat;
    csi2_crc_res_t crc;
    csi2_pkt_evt_t evt;
    fd = $fopen( "verif/csi2_testdata.txt", "r" );
    if( fd == 0 )
      begin
        $display( "test data file verif/csi2_testdata.txt could not be opened" );
        other_errs++;
        return;
      end
    while( !$feof( fd ) )
      begin
        line = "";
        n    = $fgets( line, fd );
        if( n > 0 )
          case( line.getc( 0 ) )
            "B":
              begin
                n          = $sscanf( line, "B %h %h %h %h", v, l, s, d );
                beat.valid = v[0];
                beat.last  = l[0];
                beat.strb  = s[3:0];
                beat.data  = d;
                beats_q.push_back( beat );
              end
            "E":
              begin
                n = $sscanf( line, "E %s %d %d %d %d %d", name, e_pass, e_fail, e_long,
                             e_short, e_len );
                crc.passed    = e_pass[0];
                crc.failed    = e_fail[0];
                evt.long_pkt  = e_long[0];
                evt.short_pkt = e_short[0];
                evt.len_err   = e_len[0];
                pkt_end_q.push_back( beats_q.size() );
                name_q.push_back( name );
                crc_exp_q.push_back( crc );
                evt_exp_q.push_back( evt );
              end
            "S":
              begin
                n = $sscanf( line, "S %d %d %d %d", e_short, e_long, e_fail, e_len );
                stats_exp.short_cnt   = CSI2_CNT_WIDTH'( e_short );
                stats_exp.long_cnt    = CSI2_CNT_WIDTH'( e_long );
                stats_exp.crc_err_cnt = CSI2_CNT_WIDTH'( e_fail );
                stats_exp.len_err_cnt = CSI2_CNT_WIDTH'( e_len );
                stats_seen            = 1'b1;
              end
            default:
              n = 0;   // comments and blank lines
          endcase
      end
    $fclose( fd );
  endtask

  task automatic plan_gaps();
    logic [31:0] state;
    int          total;
    state = 32'ha935_5ab6;
    total = 8 + beats_q.size() + 20;
    for( int p = 0; p < pkt_end_q.size(); p++ )
      begin
        state = lcg_next( state );
        if( p % 2 == 1 )
          gap_q.push_back( 0 );   // odd packets follow back to back
        else
          gap_q.push_back( 1 + int'( state[23:16] % 8'd3 ) );
        total += gap_q[p];
      end
    watchdog_cycles = total;
  endtask

  task automatic drive_beat( input csi2_beat_t beat );
    @( posedge clk_i );
    #1;
    pkt_i = beat;
  endtask

  task automatic run_packets();
    int b;
    b = 0;
    for( int p = 0; p < pkt_end_q.size(); p++ )
      begin
        repeat( gap_q[p] )
          drive_beat( '0 );
        while( b < pkt_end_q[p] )
          begin
            drive_beat( beats_q[b] );
            b++;
          end
        due_q.push_back( cyc + 1 );   // pulses show one cycle after the last beat
        due_pkt_q.push_back( p );
      end
    drive_beat( '0 );
  endtask

  task automatic check_crc_res( input name_t name, input csi2_crc_res_t exp,
                                input csi2_crc_res_t act );
    if( act !== exp )
      begin
        $display( "Error %0s: crc_res expected %b actual %b", name, exp, act );
        crc_errs++;
      end
  endtask

  task automatic check_pkt_evt( input name_t name, input csi2_pkt_evt_t exp,
                                input csi2_pkt_evt_t act );
    if( act !== exp )
      begin
        $display( "Error %0s: pkt_evt expected %b actual %b", name, exp, act );
        evt_errs++;
      end
  endtask

  task automatic check_stats( input csi2_stats_t exp, input csi2_stats_t act );
    if( act !== exp )
      begin
        $display( "Error final_stats: stats expected %0d/%0d/%0d/%0d actual %0d/%0d/%0d/%0d",
                  exp.short_cnt, exp.long_cnt, exp.crc_err_cnt, exp.len_err_cnt,
                  act.short_cnt, act.long_cnt, act.crc_err_cnt, act.len_err_cnt );
        stats_errs++;
      end
  endtask

  always @( negedge clk_i )
    if( checking )
      begin
        if( due_q.size() != 0 && due_q[0] == cyc )
          begin
            check_crc_res( name_q[due_pkt_q[0]], crc_exp_q[due_pkt_q[0]], crc_res_o );
            check_pkt_evt( name_q[due_pkt_q[0]], evt_exp_q[due_pkt_q[0]], pkt_evt_o );
            void'( due_q.pop_front() );
            void'( due_pkt_q.pop_front() );
          end
        else
          begin
            check_crc_res( "idle", '0, crc_res_o );
            check_pkt_evt( "idle", '0, pkt_evt_o );
          end
      end

  initial
    begin
      wait( watchdog_cycles != 0 );
      #( watchdog_cycles * 10 );
      $display( "watchdog expired after %0d cycles before the tests finished", watchdog_cycles );
      $display( "Simulation failed" );
      $finish;
    end

  initial
    begin : main_seq
      int total;
      pkt_i  = '0;
      srst_i = 1'b1;
      load_testdata();
      plan_gaps();
      repeat( 8 )
        @( posedge clk_i );
      #1;
      srst_i   = 1'b0;
      checking = 1'b1;
      if( pkt_end_q.size() == 0 || !stats_seen )
        begin
          $display( "the test data holds no packets or no expected counter line" );
          other_errs++;
        end
      else
        run_packets();
      @( posedge clk_i );
      @( negedge clk_i );   // counters have taken the last events by now
      #1;
      check_stats( stats_exp, stats_o );
      if( due_q.size() != 0 )
        begin
          $display( "%0d packet results were never checked", due_q.size() );
          other_errs++;
        end
      checking = 1'b0;
      total    = crc_errs + evt_errs + stats_errs + other_errs +
                 csi2_rx_check_i.rx_asserts.fail_cnt;
      $display( "errors: crc_res %0d, pkt_evt %0d, stats %0d, assertions %0d, other %0d",
                crc_errs, evt_errs, stats_errs, csi2_rx_check_i.rx_asserts.fail_cnt,
                other_errs );
      if( total == 0 )
        $display( "Simulation completed successfully" );
      else
        $display( "Simulation failed" );
      $finish;
    end

endmodule

`default_nettype wire
